// File: source/execPkg.sv
// ------------------------------------------------
// Execute stage shared definitions
// Word width, ALU operation codes, opcode map
// and the instruction-format views of one word
// ------------------------------------------------
package execPkg;

   // Datapath width fixed by the ISA
   localparam int wordWidth = 16;

   // ALU operations; low two bits double as shifter mode
   typedef enum logic [2:0] {
      aluRol = 3'b000,
      aluSll = 3'b001,
      aluRor = 3'b010,
      aluSrl = 3'b011,
      aluAdd = 3'b100,
      aluOr  = 3'b101,
      aluXor = 3'b110,
      aluAnd = 3'b111
   } aluOp_e;

   // Jumps
   localparam logic [4:0] opJ      = 5'b00100;
   localparam logic [4:0] opJr     = 5'b00101;
   localparam logic [4:0] opJal    = 5'b00110;
   localparam logic [4:0] opJalr   = 5'b00111;
   // Immediate arithmetic and logic
   localparam logic [4:0] opAddi   = 5'b01000;
   localparam logic [4:0] opSubi   = 5'b01001;
   localparam logic [4:0] opXori   = 5'b01010;
   localparam logic [4:0] opAndni  = 5'b01011;
   // Conditional branches, condition in bits 12:11
   localparam logic [4:0] opBeqz   = 5'b01100;
   localparam logic [4:0] opBnez   = 5'b01101;
   localparam logic [4:0] opBltz   = 5'b01110;
   localparam logic [4:0] opBgez   = 5'b01111;
   // Memory and byte loads
   localparam logic [4:0] opSt     = 5'b10000;
   localparam logic [4:0] opLd     = 5'b10001;
   localparam logic [4:0] opSlbi   = 5'b10010;
   localparam logic [4:0] opStu    = 5'b10011;
   // Immediate shifts
   localparam logic [4:0] opRoli   = 5'b10100;
   localparam logic [4:0] opSlli   = 5'b10101;
   localparam logic [4:0] opRori   = 5'b10110;
   localparam logic [4:0] opSrli   = 5'b10111;
   localparam logic [4:0] opLbi    = 5'b11000;
   localparam logic [4:0] opBtr    = 5'b11001;
   // R-format groups, funct picks the operation
   localparam logic [4:0] opShift  = 5'b11010;
   localparam logic [4:0] opArith  = 5'b11011;
   // Set instructions
   localparam logic [4:0] opSeq    = 5'b11100;
   localparam logic [4:0] opSlt    = 5'b11101;
   localparam logic [4:0] opSle    = 5'b11110;
   localparam logic [4:0] opSco    = 5'b11111;

   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] funct;
   } rFmt_t;

   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } iFmt_t;

   typedef struct packed {
      logic [4:0]  opcode;
      logic [10:0] disp;
   } jFmt_t;

   // Same 16 bits seen through each format
   typedef union packed {
      rFmt_t rFmt;
      iFmt_t iFmt;
      jFmt_t jFmt;
   } instrWord_u;

endpackage

// File: source/controlDecode.sv
// ------------------------------------------------
// Control decoder for the execute stage
// Opcode and funct bits to strobes and ALU op
// ------------------------------------------------
`timescale 1ns/10ps

module controlDecode (
   input  execPkg::instrWord_u instr,
   output logic                ldOrSt,
   output logic                setLess,
   output logic                setCarry,
   output logic                setEqual,
   output logic                immPres,
   output logic                slbi,
   output logic                btr,
   output logic                aluSrc,
   output logic                jump,
   output logic                branch,
   output logic                regJump,
   output logic                invA,
   output logic                invB,
   output execPkg::aluOp_e     aluOp
);

   logic [4:0] op;
   logic [1:0] funct;

   assign op    = instr.rFmt.opcode;
   assign funct = instr.rFmt.funct;

   always_comb begin
      // Everything idle unless the opcode says otherwise
      ldOrSt   = 1'b0;
      setLess  = 1'b0;
      setCarry = 1'b0;
      setEqual = 1'b0;
      immPres  = 1'b0;
      slbi     = 1'b0;
      btr      = 1'b0;
      aluSrc   = 1'b0;
      jump     = 1'b0;
      branch   = 1'b0;
      regJump  = 1'b0;
      invA     = 1'b0;
      invB     = 1'b0;

      case (op)
         execPkg::opSt, execPkg::opLd, execPkg::opStu: begin
            ldOrSt = 1'b1;
            aluSrc = 1'b1;
         end
         execPkg::opAddi, execPkg::opXori,
         execPkg::opRoli, execPkg::opSlli, execPkg::opRori, execPkg::opSrli,
         execPkg::opLbi: begin
            immPres = 1'b1;
            aluSrc  = 1'b1;
         end
         execPkg::opSubi: begin
            immPres = 1'b1;
            aluSrc  = 1'b1;
            invA    = 1'b1;
         end
         execPkg::opAndni: begin
            immPres = 1'b1;
            aluSrc  = 1'b1;
            invB    = 1'b1;
         end
         execPkg::opSlbi: begin
            immPres = 1'b1;
            aluSrc  = 1'b1;
            slbi    = 1'b1;
         end
         execPkg::opBtr: btr = 1'b1;
         // funct 01 is SUB, 11 is ANDN
         execPkg::opArith: begin
            invA = (funct == 2'b01);
            invB = (funct == 2'b11);
         end
         execPkg::opSeq: setEqual = 1'b1;
         execPkg::opSlt, execPkg::opSle: setLess = 1'b1;
         execPkg::opSco: setCarry = 1'b1;
         execPkg::opBeqz, execPkg::opBnez, execPkg::opBltz, execPkg::opBgez: begin
            branch = 1'b1;
         end
         execPkg::opJ, execPkg::opJal: jump = 1'b1;
         execPkg::opJr, execPkg::opJalr: begin
            jump    = 1'b1;
            regJump = 1'b1;
         end
         default: ;
      endcase

      // Op field position depends on the format
      if (ldOrSt)
         aluOp = execPkg::aluOp_e'(op[4:2]);
      else if (immPres)
         aluOp = execPkg::aluOp_e'({~op[2], op[1:0]});
      else
         aluOp = execPkg::aluOp_e'({op[0], funct});

      // Subtract and the set compares all run through the adder
      if (invA | setLess | setEqual | setCarry)
         aluOp = execPkg::aluAdd;
   end

endmodule

// File: source/barrelShifter.sv
// ------------------------------------------------
// Barrel shifter, four log stages
// Rotate/shift left, rotate/shift right logical
// ------------------------------------------------
`timescale 1ns/10ps

module barrelShifter (
   input  logic [execPkg::wordWidth-1:0] data,
   input  logic [3:0]                    amount,
   input  logic [1:0]                    mode,
   output logic [execPkg::wordWidth-1:0] shifted
);

   localparam int W = execPkg::wordWidth;

   // stage[0] is the input, stage[4] the result
   logic [W-1:0] stage [0:4];

   assign stage[0] = data;

   genvar i;
   generate
      for (i = 0; i < 4; i++) begin : g_stage
         localparam int S = 1 << i;
         logic [W-1:0] moved;

         // mode 00 rol, 01 sll, 10 ror, 11 srl
         always_comb begin
            case (mode)
               2'b00:   moved = (stage[i] << S) | (stage[i] >> (W - S));
               2'b01:   moved = stage[i] << S;
               2'b10:   moved = (stage[i] >> S) | (stage[i] << (W - S));
               default: moved = stage[i] >> S;
            endcase
         end

         // Stage only acts when its amount bit is set
         assign stage[i+1] = amount[i] ? moved : stage[i];
      end
   endgenerate

   assign shifted = stage[4];

endmodule

// File: source/alu.sv
// ------------------------------------------------
// ALU for the execute stage
// Add, or, xor, and, plus shifts through the
// barrel shifter; carry, zero and overflow flags
// ------------------------------------------------
`timescale 1ns/10ps

module alu (
   input  logic [execPkg::wordWidth-1:0] inA,
   input  logic [execPkg::wordWidth-1:0] inB,
   input  logic                          invA,
   input  logic                          invB,
   input  execPkg::aluOp_e               op,
   input  logic                          cin,
   output logic [execPkg::wordWidth-1:0] out,
   output logic                          carryOut,
   output logic                          zero,
   output logic                          ofl
);

   localparam int W = execPkg::wordWidth;

   logic [W-1:0] opA;
   logic [W-1:0] opB;
   logic [W-1:0] sum;
   logic [W-1:0] shifted;

   // Optional inversion ahead of every operation
   assign opA = invA ? ~inA : inA;
   assign opB = invB ? ~inB : inB;

   // One extra bit catches the carry
   assign {carryOut, sum} = {1'b0, opA} + {1'b0, opB} + {{W{1'b0}}, cin};

   // Shift amount is the low nibble of operand B
   barrelShifter u_shifter (
      .data    (opA),
      .amount  (opB[3:0]),
      .mode    (op[1:0]),
      .shifted (shifted)
   );

   always_comb begin
      case (op)
         execPkg::aluAdd: out = sum;
         execPkg::aluOr:  out = opA | opB;
         execPkg::aluXor: out = opA ^ opB;
         execPkg::aluAnd: out = opA & opB;
         default:         out = shifted;
      endcase
   end

   // Overflow only has meaning for the adder
   // Like-signed operands whose sum flips sign
   assign ofl = (op == execPkg::aluAdd) &&
                (opA[W-1] == opB[W-1]) &&
                (sum[W-1] != opA[W-1]);

   assign zero = (out == '0);

endmodule

// File: source/branchUnit.sv
// ------------------------------------------------
// Branch and jump resolution
// Evaluates the condition on rs and picks
// the next program counter
// ------------------------------------------------
`timescale 1ns/10ps

module branchUnit (
   input  logic [4:0]                    opcode,
   input  logic                          branch,
   input  logic                          jump,
   input  logic                          regJump,
   input  logic [execPkg::wordWidth-1:0] rs,
   input  logic [execPkg::wordWidth-1:0] pc,
   input  logic [execPkg::wordWidth-1:0] offset,
   output logic [execPkg::wordWidth-1:0] nextPc
);

   localparam int W = execPkg::wordWidth;

   logic         condMet;
   logic         taken;
   logic [W-1:0] base;
   logic [W-1:0] target;

   // Bits 12:11 of the instruction pick the test
   always_comb begin
      case (opcode[1:0])
         2'b00:   condMet = (rs == '0);
         2'b01:   condMet = (rs != '0);
         2'b10:   condMet = rs[W-1];
         default: condMet = ~rs[W-1];
      endcase
   end

   // Guard against strobes from outside the branch group
   assign taken = branch && (opcode[4:2] == 3'b011) && condMet;

   // JR and JALR are relative to rs, the rest to pc
   assign base   = regJump ? rs : pc;
   assign target = base + offset;

   assign nextPc = (jump | taken) ? target : pc;

endmodule

// File: source/execute.sv
// ------------------------------------------------
// Execute datapath
// Operand select, ALU, set compares, bit
// reverse and next PC resolution
// ------------------------------------------------
`timescale 1ns/10ps

module execute (
   input  logic                          ldOrSt,
   input  logic                          setLess,
   input  logic                          setCarry,
   input  logic                          setEqual,
   input  logic                          immPres,
   input  logic                          slbi,
   input  logic                          btr,
   input  logic                          aluSrc,
   input  logic                          jump,
   input  logic                          branch,
   input  logic                          regJump,
   input  logic                          invA,
   input  logic                          invB,
   input  execPkg::aluOp_e               aluOp,
   input  execPkg::instrWord_u           instr,
   input  logic [execPkg::wordWidth-1:0] regData1,
   input  logic [execPkg::wordWidth-1:0] regData2,
   input  logic [execPkg::wordWidth-1:0] immVal,
   input  logic [execPkg::wordWidth-1:0] branchVal,
   input  logic [execPkg::wordWidth-1:0] jumpVal,
   input  logic [execPkg::wordWidth-1:0] pc,
   output logic [execPkg::wordWidth-1:0] result,
   output logic [execPkg::wordWidth-1:0] storeData,
   output logic [execPkg::wordWidth-1:0] nextPc,
   output logic                          zero,
   output logic                          ofl
);

   localparam int W = execPkg::wordWidth;

   logic         lbiOp;
   logic [W-1:0] inA;
   logic [W-1:0] inB;
   logic [W-1:0] aluOut;
   logic         carry;
   logic         setRes;
   logic [W-1:0] reversed;
   logic [W-1:0] jumpExt;
   logic [W-1:0] branchExt;
   logic [W-1:0] offset;

   // LBI passes the immediate straight through the adder
   assign lbiOp = immPres && (instr.iFmt.opcode == execPkg::opLbi);

   assign inA = lbiOp ? '0 : (slbi ? (regData1 << 8) : regData1);
   assign inB = aluSrc ? immVal : regData2;

   // Carry-in completes the two's complement for SUB
   alu u_alu (
      .inA      (inA),
      .inB      (inB),
      .invA     (invA),
      .invB     (invB),
      .op       (aluOp),
      .cin      (invA),
      .out      (aluOut),
      .carryOut (carry),
      .zero     (zero),
      .ofl      (ofl)
   );

   // Opcode bit 11 splits SLT from SLE
   always_comb begin
      if (setCarry)
         setRes = carry;
      else if (setEqual)
         setRes = (inA == inB);
      else if (instr.rFmt.opcode[0])
         setRes = $signed(inA) < $signed(inB);
      else
         setRes = $signed(inA) <= $signed(inB);
   end

   always_comb begin
      for (int i = 0; i < W; i++)
         reversed[i] = inA[W-1-i];
   end

   assign result = (setLess | setEqual | setCarry) ? {{(W-1){1'b0}}, setRes} :
                   btr ? reversed : aluOut;

   // Only memory ops carry meaningful store data
   assign storeData = ldOrSt ? regData2 : '0;

   // Sign extend the displacements
   assign jumpExt   = {{(W-11){jumpVal[10]}}, jumpVal[10:0]};
   assign branchExt = {{(W-8){branchVal[7]}}, branchVal[7:0]};

   // Register jumps use the immediate as their offset
   assign offset = (jump & ~regJump) ? jumpExt :
                   branch ? branchExt : immVal;

   branchUnit u_branch (
      .opcode  (instr.jFmt.opcode),
      .branch  (branch),
      .jump    (jump),
      .regJump (regJump),
      .rs      (regData1),
      .pc      (pc),
      .offset  (offset),
      .nextPc  (nextPc)
   );

endmodule

// File: source/executeStage.sv
// ------------------------------------------------
// Execute stage top level
// Decoder and datapath feeding the EX/MEM
// register, one cycle of latency
// ------------------------------------------------
`timescale 1ns/10ps

module executeStage (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          instrValid,
   input  execPkg::instrWord_u           instr,
   input  logic [execPkg::wordWidth-1:0] pc,
   input  logic [execPkg::wordWidth-1:0] regData1,
   input  logic [execPkg::wordWidth-1:0] regData2,
   input  logic [execPkg::wordWidth-1:0] immVal,
   input  logic [execPkg::wordWidth-1:0] branchVal,
   input  logic [execPkg::wordWidth-1:0] jumpVal,
   output logic                          resultValid,
   output logic [execPkg::wordWidth-1:0] result,
   output logic [execPkg::wordWidth-1:0] storeData,
   output logic [execPkg::wordWidth-1:0] nextPc,
   output logic                          zero,
   output logic                          ofl
);

   localparam int W = execPkg::wordWidth;

   // Decoder strobes
   logic ldOrSt, setLess, setCarry, setEqual, immPres, slbi, btr;
   logic aluSrc, jump, branch, regJump, invA, invB;
   execPkg::aluOp_e aluOp;

   // Combinational datapath outputs
   logic [W-1:0] exResult;
   logic [W-1:0] exStoreData;
   logic [W-1:0] exNextPc;
   logic         exZero;
   logic         exOfl;

   controlDecode u_decode (
      .instr    (instr),
      .ldOrSt   (ldOrSt),
      .setLess  (setLess),
      .setCarry (setCarry),
      .setEqual (setEqual),
      .immPres  (immPres),
      .slbi     (slbi),
      .btr      (btr),
      .aluSrc   (aluSrc),
      .jump     (jump),
      .branch   (branch),
      .regJump  (regJump),
      .invA     (invA),
      .invB     (invB),
      .aluOp    (aluOp)
   );

   execute u_execute (
      .ldOrSt    (ldOrSt),
      .setLess   (setLess),
      .setCarry  (setCarry),
      .setEqual  (setEqual),
      .immPres   (immPres),
      .slbi      (slbi),
      .btr       (btr),
      .aluSrc    (aluSrc),
      .jump      (jump),
      .branch    (branch),
      .regJump   (regJump),
      .invA      (invA),
      .invB      (invB),
      .aluOp     (aluOp),
      .instr     (instr),
      .regData1  (regData1),
      .regData2  (regData2),
      .immVal    (immVal),
      .branchVal (branchVal),
      .jumpVal   (jumpVal),
      .pc        (pc),
      .result    (exResult),
      .storeData (exStoreData),
      .nextPc    (exNextPc),
      .zero      (exZero),
      .ofl       (exOfl)
   );

   // EX/MEM register, all outputs read zero out of reset
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         resultValid <= 1'b0;
         result      <= '0;
         storeData   <= '0;
         nextPc      <= '0;
         zero        <= 1'b0;
         ofl         <= 1'b0;
      end else begin
         resultValid <= instrValid;
         result      <= exResult;
         storeData   <= exStoreData;
         nextPc      <= exNextPc;
         zero        <= exZero;
         ofl         <= exOfl;
      end
   end

endmodule

// File: tests/execVectors.svh
// ------------------------------------------------
// Execute stage test vectors
// One addRow call per instruction, applied in
// order, one per cycle
// ------------------------------------------------
`ifndef EXEC_VECTORS_SVH
`define EXEC_VECTORS_SVH

// Columns: name, opcode, funct, regData1, regData2, immVal, displacement,
// result, nextPc, {zero, ofl}, which outputs to check
task automatic fillTable();
   // Register ALU ops, operand B from regData2
   addRow("ADD", execPkg::opArith, 0, 'h1234, 'h0101, 0, 0, 'h1335, 'h200, 2'b00, ckFlag);
   addRow("ADD ofl", execPkg::opArith, 0, 'h7FFF, 'h0001, 0, 0, 'h8000, 'h200, 2'b01, ckFlag);
   addRow("ADD zero", execPkg::opArith, 0, 'hFFFF, 'h0001, 0, 0, 'h0000, 'h200, 2'b10, ckFlag);
   // SUB is rt minus rs
   addRow("SUB", execPkg::opArith, 1, 'h0003, 'h000A, 0, 0, 'h0007, 'h200, 2'b00, ckFlag);
   addRow("SUB zero", execPkg::opArith, 1, 'h0055, 'h0055, 0, 0, 'h0000, 'h200, 2'b10, ckFlag);
   addRow("XOR", execPkg::opArith, 2, 'hF0F0, 'hFF00, 0, 0, 'h0FF0, 'h200, 2'b00, ckFlag);
   addRow("ANDN", execPkg::opArith, 3, 'hF0F0, 'hFF00, 0, 0, 'h00F0, 'h200, 2'b00, ckFlag);
   // Shift amount is the low nibble of regData2
   addRow("ROL", execPkg::opShift, 0, 'h8001, 'h0004, 0, 0, 'h0018, 'h200, 2'b00, ckFlag);
   addRow("SLL", execPkg::opShift, 1, 'h8001, 'h0004, 0, 0, 'h0010, 'h200, 2'b00, ckFlag);
   addRow("ROR", execPkg::opShift, 2, 'h8001, 'h0004, 0, 0, 'h1800, 'h200, 2'b00, ckFlag);
   addRow("SRL", execPkg::opShift, 3, 'h8001, 'h0004, 0, 0, 'h0800, 'h200, 2'b00, ckFlag);
   addRow("SLL zero", execPkg::opShift, 1, 'h8000, 'h0001, 0, 0, 'h0000, 'h200, 2'b10, ckFlag);

   // Immediate forms, regData2 must be ignored
   addRow("ADDI", execPkg::opAddi, 0, 'h0100, 'hDEAD, 'h0010, 0, 'h0110, 'h200, 2'b00, ckFlag);
   addRow("SUBI", execPkg::opSubi, 0, 'h0005, 'hDEAD, 'h0003, 0, 'hFFFE, 'h200, 2'b00, ckFlag);
   addRow("XORI", execPkg::opXori, 0, 'h00FF, 'hDEAD, 'h000F, 0, 'h00F0, 'h200, 2'b00, ckFlag);
   addRow("ANDNI", execPkg::opAndni, 0, 'h00FF, 'hDEAD, 'h0003, 0, 'h00FC, 'h200, 2'b00, ckFlag);
   addRow("ROLI", execPkg::opRoli, 0, 'h1234, 'hDEAD, 'h0008, 0, 'h3412, 'h200, 2'b00, ckFlag);
   addRow("SLLI", execPkg::opSlli, 0, 'h1234, 'hDEAD, 'h0008, 0, 'h3400, 'h200, 2'b00, ckFlag);
   addRow("RORI", execPkg::opRori, 0, 'h1234, 'hDEAD, 'h0004, 0, 'h4123, 'h200, 2'b00, ckFlag);
   addRow("SRLI", execPkg::opSrli, 0, 'h1234, 'hDEAD, 'h0004, 0, 'h0123, 'h200, 2'b00, ckFlag);
   addRow("SLBI", execPkg::opSlbi, 0, 'h0012, 'hDEAD, 'h0034, 0, 'h1234, 'h200, 2'b00, ckFlag);
   // LBI ignores regData1
   addRow("LBI", execPkg::opLbi, 0, 'h5555, 'hDEAD, 'hFF80, 0, 'hFF80, 'h200, 2'b00, ckFlag);

   // Set compares give exactly 1 or 0, signed for SLT and SLE
   addRow("SEQ 1", execPkg::opSeq, 0, 'h1234, 'h1234, 0, 0, 'h0001, 'h200, 2'b00, ckRes);
   addRow("SEQ 0", execPkg::opSeq, 0, 'h1234, 'h1235, 0, 0, 'h0000, 'h200, 2'b00, ckRes);
   addRow("SLT 1", execPkg::opSlt, 0, 'hFFFF, 'h0001, 0, 0, 'h0001, 'h200, 2'b00, ckRes);
   addRow("SLT 0", execPkg::opSlt, 0, 'h0005, 'h0005, 0, 0, 'h0000, 'h200, 2'b00, ckRes);
   addRow("SLE 1", execPkg::opSle, 0, 'h0005, 'h0005, 0, 0, 'h0001, 'h200, 2'b00, ckRes);
   addRow("SLE 0", execPkg::opSle, 0, 'h0001, 'h8000, 0, 0, 'h0000, 'h200, 2'b00, ckRes);
   addRow("SCO 1", execPkg::opSco, 0, 'hFFFF, 'h0001, 0, 0, 'h0001, 'h200, 2'b00, ckRes);
   addRow("SCO 0", execPkg::opSco, 0, 'h0001, 'h0001, 0, 0, 'h0000, 'h200, 2'b00, ckRes);
   addRow("BTR", execPkg::opBtr, 0, 'h1234, 0, 0, 0, 'h2C48, 'h200, 2'b00, ckRes);
   addRow("BTR msb", execPkg::opBtr, 0, 'h0001, 0, 0, 0, 'h8000, 'h200, 2'b00, ckRes);

   // Branches with rs zero, negative, positive
   // Only the low 8 displacement bits count
   addRow("BEQZ zero", execPkg::opBeqz, 0, 'h0000, 0, 0, 'h310, 0, 'h210, 2'b00, ckPc);
   addRow("BEQZ neg", execPkg::opBeqz, 0, 'h8004, 0, 0, 'h310, 0, 'h200, 2'b00, ckPc);
   addRow("BEQZ pos", execPkg::opBeqz, 0, 'h0004, 0, 0, 'h310, 0, 'h200, 2'b00, ckPc);
   addRow("BNEZ zero", execPkg::opBnez, 0, 'h0000, 0, 0, 'h0F0, 0, 'h200, 2'b00, ckPc);
   addRow("BNEZ neg", execPkg::opBnez, 0, 'h8004, 0, 0, 'h0F0, 0, 'h1F0, 2'b00, ckPc);
   addRow("BNEZ pos", execPkg::opBnez, 0, 'h0004, 0, 0, 'h0F0, 0, 'h1F0, 2'b00, ckPc);
   addRow("BLTZ zero", execPkg::opBltz, 0, 'h0000, 0, 0, 'h008, 0, 'h200, 2'b00, ckPc);
   addRow("BLTZ neg", execPkg::opBltz, 0, 'h8004, 0, 0, 'h008, 0, 'h208, 2'b00, ckPc);
   addRow("BLTZ pos", execPkg::opBltz, 0, 'h0004, 0, 0, 'h008, 0, 'h200, 2'b00, ckPc);
   addRow("BGEZ zero", execPkg::opBgez, 0, 'h0000, 0, 0, 'h0FC, 0, 'h1FC, 2'b00, ckPc);
   addRow("BGEZ neg", execPkg::opBgez, 0, 'h8004, 0, 0, 'h0FC, 0, 'h200, 2'b00, ckPc);
   addRow("BGEZ pos", execPkg::opBgez, 0, 'h0004, 0, 0, 'h0FC, 0, 'h1FC, 2'b00, ckPc);

   // Jumps, 11-bit displacement or regData1 plus immVal
   addRow("J", execPkg::opJ, 0, 0, 0, 0, 'h100, 0, 'h300, 2'b00, ckPc);
   addRow("JAL", execPkg::opJal, 0, 0, 0, 0, 'h7F0, 0, 'h1F0, 2'b00, ckPc);
   addRow("JR", execPkg::opJr, 0, 'h1000, 0, 'h0022, 'h100, 0, 'h1022, 2'b00, ckPc);
   addRow("JALR", execPkg::opJalr, 0, 'h3000, 0, 'hFFFE, 'h100, 0, 'h2FFE, 2'b00, ckPc);

   // Address is regData1 plus immVal, store data is regData2
   addRow("LD", execPkg::opLd, 0, 'h1000, 'hBEEF, 'h0006, 0, 'h1006, 'h200, 2'b00, ckMem);
   addRow("ST", execPkg::opSt, 0, 'h2000, 'h1234, 'hFFFE, 0, 'h1FFE, 'h200, 2'b00, ckMem);
endtask

`endif

// File: tests/executeStageTb.sv
// ------------------------------------------------
// Testbench for the execute stage
// Table rows then random ADDs, one per cycle,
// each checked one cycle after it is driven
// ------------------------------------------------
`timescale 1ns/10ps

module executeStageTb;

   localparam int W = execPkg::wordWidth;
   localparam int clkPeriod = 20;
   localparam int resetCycles = 8;
   localparam int randomRows = 64;
   localparam logic [31:0] randomSeed = 32'h03850510;
   localparam logic [W-1:0] pcBase = 16'h0200;

   // Outputs checked besides resultValid and nextPc
   // Bit 2 result, bit 1 storeData, bit 0 zero and ofl
   localparam logic [2:0] ckPc = 3'b000;
   localparam logic [2:0] ckRes = 3'b100;
   localparam logic [2:0] ckFlag = 3'b101;
   localparam logic [2:0] ckMem = 3'b110;

   typedef struct packed {
      logic [4:0]   op;
      logic [1:0]   funct;
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W-1:0] imm;
      logic [W-1:0] disp;
      logic [W-1:0] expRes;
      logic [W-1:0] expNext;
      logic [1:0]   flags;
      logic [2:0]   chk;
   } vecRow_t;

   logic                clk;
   logic                rstN;
   logic                instrValid;
   execPkg::instrWord_u instr;
   logic [W-1:0]        pc;
   logic [W-1:0]        regData1;
   logic [W-1:0]        regData2;
   logic [W-1:0]        immVal;
   logic [W-1:0]        branchVal;
   logic [W-1:0]        jumpVal;
   logic                resultValid;
   logic [W-1:0]        result;
   logic [W-1:0]        storeData;
   logic [W-1:0]        nextPc;
   logic                zero;
   logic                ofl;

   vecRow_t     rows[$];
   string       rowNames[$];
   logic [31:0] rngState;
   bit          tableReady;

   executeStage u_dut (
      .clk         (clk),
      .rstN        (rstN),
      .instrValid  (instrValid),
      .instr       (instr),
      .pc          (pc),
      .regData1    (regData1),
      .regData2    (regData2),
      .immVal      (immVal),
      .branchVal   (branchVal),
      .jumpVal     (jumpVal),
      .resultValid (resultValid),
      .result      (result),
      .storeData   (storeData),
      .nextPc      (nextPc),
      .zero        (zero),
      .ofl         (ofl)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   task automatic addRow(input string name, input logic [4:0] op, input logic [1:0] funct,
                         input logic [W-1:0] a, b, imm, disp, expRes, expNext,
                         input logic [1:0] flags, input logic [2:0] chk);
      vecRow_t row;
      row.op      = op;
      row.funct   = funct;
      row.a       = a;
      row.b       = b;
      row.imm     = imm;
      row.disp    = disp;
      row.expRes  = expRes;
      row.expNext = expNext;
      row.flags   = flags;
      row.chk     = chk;
      rows.push_back(row);
      rowNames.push_back(name);
   endtask

   `include "execVectors.svh"

   // 32-bit xorshift with shifts of 13, 17 and 5
   function automatic logic [31:0] nextRandom(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Random ADDs with sum and flags taken from a sign-extended 17-bit add
   task automatic addRandomRows();
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W:0]   wide;
      logic [1:0]   flags;
      for (int n = 0; n < randomRows; n++) begin
         rngState = nextRandom(rngState);
         a = rngState[15:0];
         b = rngState[31:16];
         wide = {a[W-1], a} + {b[W-1], b};
         flags[1] = (wide[W-1:0] == '0);
         // Overflow when the extra sign bit disagrees with the result sign
         flags[0] = wide[W] ^ wide[W-1];
         addRow("ADD random", execPkg::opArith, 2'd0, a, b, '0, '0, wide[W-1:0], pcBase,
                flags, ckFlag);
      end
   endtask

   task automatic checkValue(input string testName, input string what,
                             input logic [W-1:0] expected, input logic [W-1:0] actual);
      if (actual !== expected) begin
         $display("FAIL %s %s: expected %h actual %h", testName, what, expected, actual);
         $display("CHECKS FAILED");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // Operands for one instruction with register fields left at 0
   task automatic driveRow(input vecRow_t row);
      instrValid <= 1'b1;
      instr      <= {row.op, 9'b0, row.funct};
      pc         <= pcBase;
      regData1   <= row.a;
      regData2   <= row.b;
      immVal     <= row.imm;
      branchVal  <= row.disp;
      jumpVal    <= row.disp;
   endtask

   task automatic checkRow(input int idx);
      vecRow_t row;
      string   name;
      row  = rows[idx];
      name = rowNames[idx];
      checkValue(name, "resultValid", 1, resultValid);
      if (row.chk[2])
         checkValue(name, "result", row.expRes, result);
      if (row.chk[1])
         checkValue(name, "storeData", row.b, storeData);
      if (row.chk[0]) begin
         checkValue(name, "zero", row.flags[1], zero);
         checkValue(name, "ofl", row.flags[0], ofl);
      end
      checkValue(name, "nextPc", row.expNext, nextPc);
   endtask

   initial begin
      int total;
      rstN       = 1'b0;
      instrValid = 1'b0;
      instr      = '0;
      pc         = '0;
      regData1   = '0;
      regData2   = '0;
      immVal     = '0;
      branchVal  = '0;
      jumpVal    = '0;
      rngState   = randomSeed;
      fillTable();
      addRandomRows();
      total = rows.size();
      tableReady = 1'b1;

      repeat (resetCycles) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      checkValue("reset", "resultValid", 0, resultValid);
      checkValue("reset", "result", 0, result);
      checkValue("reset", "nextPc", 0, nextPc);

      // Row i goes in while row i-1 comes out
      for (int i = 0; i < total; i++) begin
         @(posedge clk);
         driveRow(rows[i]);
         @(negedge clk);
         if (i == 0)
            checkValue("idle", "resultValid", 0, resultValid);
         else
            checkRow(i - 1);
      end
      @(posedge clk);
      instrValid <= 1'b0;
      @(negedge clk);
      checkRow(total - 1);
      // Valid drops one cycle after instrValid
      @(posedge clk);
      @(negedge clk);
      checkValue("drain", "resultValid", 0, resultValid);

      $display("ALL CHECKS PASSED");
      $finish;
   end

   // Watchdog sized from the row count
   initial begin
      int limit;
      wait (tableReady);
      limit = (rows.size() + 20) * clkPeriod;
      #(limit);
      $display("Timeout: the run did not finish within %0d ns", limit);
      $display("CHECKS FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: all.f
+incdir+tests
source/execPkg.sv
source/controlDecode.sv
source/barrelShifter.sv
source/alu.sv
source/branchUnit.sv
source/execute.sv
source/executeStage.sv
tests/executeStageTb.sv
